//--- hdl/render_pkg.sv
package render_pkg;

    localparam int MAP_H = 160;
    localparam int MAP_V = 120;
    localparam int H_W = 8;
    localparam int V_W = 7;
    localparam int IDX_W = 15;

    localparam int PLAYER_SIZE = 8;
    localparam int BULLET_SIZE = 4;

    // Caption windows, 1-based corners and sizes in pixels.
    localparam int START_CAP_H_MIN = 41;
    localparam int START_CAP_V_MIN = 51;
    localparam int START_CAP_W = 80;
    localparam int START_CAP_H = 20;
    localparam int WIN_CAP_H_MIN = 57;
    localparam int LOSE_CAP_H_MIN = 49;
    localparam int END_CAP_V_MIN = 46;
    localparam int END_CAP_W = 48;
    localparam int END_CAP_H = 16;

    localparam logic [7:0] REG_CTRL = 8'h00;
    localparam logic [7:0] REG_P1_POS = 8'h04;
    localparam logic [7:0] REG_P2_POS = 8'h08;
    localparam logic [7:0] REG_B1_POS = 8'h0C;
    localparam logic [7:0] REG_B2_POS = 8'h10;
    localparam logic [7:0] REG_P1_MASK = 8'h40; // Eight rows, 4 bytes apart.
    localparam logic [7:0] REG_P2_MASK = 8'h60;
    localparam logic [7:0] REG_B1_MASK = 8'h80;
    localparam logic [7:0] REG_B2_MASK = 8'h84;

    typedef logic [H_W-1:0] h_t;
    typedef logic [V_W-1:0] v_t;
    typedef logic [IDX_W-1:0] idx_t;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_PLAY = 2'd1,
        ST_WIN  = 2'd2,
        ST_LOSE = 2'd3
    } game_state_e;

    typedef enum logic [3:0] {
        OBJ_MAP, OBJ_PLAYER1, OBJ_PLAYER1_SHIELD, OBJ_PLAYER2, OBJ_PLAYER2_SHIELD,
        OBJ_BULLET1, OBJ_BULLET2, OBJ_START_CAPTION, OBJ_START_BG,
        OBJ_WIN_CAPTION, OBJ_LOSE_CAPTION, OBJ_END_BG, OBJ_BLANK
    } object_id_e;

endpackage

//--- hdl/sprite_cfg_if.sv
`timescale 1ns/100ps

interface sprite_cfg_if #(
    parameter int SIZE = render_pkg::PLAYER_SIZE
);
    logic signed [render_pkg::H_W-1:0] x;
    logic signed [render_pkg::V_W-1:0] y;
    logic                              en;
    logic [SIZE*SIZE-1:0]              mask; // Row r, column c at bit r*SIZE+c.

    modport cfg (output x, y, en, mask);
    modport hit (input x, y, en, mask);
endinterface

//--- hdl/sprite_regs.sv
`timescale 1ns/100ps

module sprite_regs (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_psel,
    input  logic                    i_penable,
    input  logic                    i_pwrite,
    input  logic [7:0]              i_paddr,
    input  logic [31:0]             i_pwdata,
    output logic [31:0]             o_prdata,
    output logic                    o_pready,
    output logic                    o_pslverr,
    output render_pkg::game_state_e o_game_state,
    output logic                    o_p1_shield,
    output logic                    o_p2_shield,
    sprite_cfg_if.cfg               player1,
    sprite_cfg_if.cfg               player2,
    sprite_cfg_if.cfg               bullet1,
    sprite_cfg_if.cfg               bullet2
);
    localparam int PS = render_pkg::PLAYER_SIZE;
    localparam int BS = render_pkg::BULLET_SIZE;

    render_pkg::game_state_e           game_state;
    logic [1:0]                        shield;
    logic signed [render_pkg::H_W-1:0] pos_x [4]; // P1, P2, B1, B2.
    logic signed [render_pkg::V_W-1:0] pos_y [4];
    logic [3:0]                        pos_en;
    logic [PS-1:0][PS-1:0]             p_mask [2];
    logic [BS*BS-1:0]                  b_mask [2];

    logic       is_ctrl, is_pos, is_pmask, is_bmask;
    logic [1:0] pos_sel;
    logic       p_sel;
    logic [2:0] row;
    logic       wr_en;

    assign is_ctrl  = (i_paddr == render_pkg::REG_CTRL);
    assign is_pos   = (i_paddr[1:0] == 2'b00) && (i_paddr >= render_pkg::REG_P1_POS)
                      && (i_paddr <= render_pkg::REG_B2_POS);
    assign is_pmask = (i_paddr[1:0] == 2'b00) && (i_paddr >= render_pkg::REG_P1_MASK)
                      && (i_paddr < render_pkg::REG_B1_MASK);
    assign is_bmask = (i_paddr == render_pkg::REG_B1_MASK)
                      || (i_paddr == render_pkg::REG_B2_MASK);
    assign pos_sel  = 2'(i_paddr[4:2] - 3'd1);
    assign p_sel    = (i_paddr >= render_pkg::REG_P2_MASK); // Second player bank.
    assign row      = i_paddr[4:2];
    assign wr_en    = i_psel && i_penable && i_pwrite;

    assign o_pready  = 1'b1; // No wait states.
    assign o_pslverr = i_psel && i_penable && !(is_ctrl || is_pos || is_pmask || is_bmask);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            game_state <= render_pkg::ST_IDLE;
            shield     <= '0;
            pos_x      <= '{default: '0};
            pos_y      <= '{default: '0};
            pos_en     <= '0;
            p_mask     <= '{default: '0};
            b_mask     <= '{default: '0};
        end else if (wr_en) begin
            if (is_ctrl) begin
                game_state <= render_pkg::game_state_e'(i_pwdata[1:0]);
                shield     <= i_pwdata[3:2];
            end
            if (is_pos) begin
                pos_x[pos_sel]  <= i_pwdata[7:0];
                pos_y[pos_sel]  <= i_pwdata[22:16];
                pos_en[pos_sel] <= i_pwdata[31];
            end
            if (is_pmask) begin
                p_mask[p_sel][row] <= i_pwdata[PS-1:0];
            end
            if (is_bmask) begin
                b_mask[i_paddr[2]] <= i_pwdata[BS*BS-1:0];
            end
        end
    end

    always_comb begin
        o_prdata = '0; // Unused bits and unmapped reads.
        if (is_ctrl) begin
            o_prdata[3:0] = {shield, game_state};
        end
        if (is_pos) begin
            o_prdata[7:0]   = pos_x[pos_sel];
            o_prdata[22:16] = pos_y[pos_sel];
            o_prdata[31]    = pos_en[pos_sel];
        end
        if (is_pmask) begin
            o_prdata[PS-1:0] = p_mask[p_sel][row];
        end
        if (is_bmask) begin
            o_prdata[BS*BS-1:0] = b_mask[i_paddr[2]];
        end
    end

    assign o_game_state = game_state;
    assign o_p1_shield  = shield[0];
    assign o_p2_shield  = shield[1];

    assign player1.x    = pos_x[0];
    assign player1.y    = pos_y[0];
    assign player1.en   = pos_en[0];
    assign player1.mask = p_mask[0];
    assign player2.x    = pos_x[1];
    assign player2.y    = pos_y[1];
    assign player2.en   = pos_en[1];
    assign player2.mask = p_mask[1];
    assign bullet1.x    = pos_x[2];
    assign bullet1.y    = pos_y[2];
    assign bullet1.en   = pos_en[2];
    assign bullet1.mask = b_mask[0];
    assign bullet2.x    = pos_x[3];
    assign bullet2.y    = pos_y[3];
    assign bullet2.en   = pos_en[3];
    assign bullet2.mask = b_mask[1];

endmodule

//--- hdl/sprite_hit.sv
`timescale 1ns/100ps

module sprite_hit #(
    parameter int SIZE = render_pkg::PLAYER_SIZE
) (
    sprite_cfg_if.hit         cfg,
    input  render_pkg::h_t    i_vga_h,
    input  render_pkg::v_t    i_vga_v,
    output logic              o_hit,
    output logic              o_opaque,
    output render_pkg::idx_t  o_index
);
    localparam int REL_W = $clog2(SIZE);

    render_pkg::h_t   h_min, rel_h;
    render_pkg::v_t   v_min, rel_v;
    logic [REL_W-1:0] row, col;

    // Sprite origin sits at the map centre, y grows upward.
    assign h_min = cfg.x + render_pkg::h_t'((render_pkg::MAP_H - SIZE) / 2 + 1);
    assign v_min = render_pkg::v_t'((render_pkg::MAP_V - SIZE) / 2 + 1) - cfg.y;

    assign rel_h = i_vga_h - h_min; // Wraps large when left of box.
    assign rel_v = i_vga_v - v_min;
    assign col   = rel_h[REL_W-1:0];
    assign row   = rel_v[REL_W-1:0];

    assign o_hit    = cfg.en && (rel_h < SIZE) && (rel_v < SIZE);
    assign o_opaque = o_hit && cfg.mask[row * SIZE + col];
    assign o_index  = render_pkg::idx_t'(row * SIZE + col);

endmodule

//--- hdl/caption_select.sv
`timescale 1ns/100ps

module caption_select (
    input  render_pkg::game_state_e i_game_state,
    input  render_pkg::h_t          i_vga_h,
    input  render_pkg::v_t          i_vga_v,
    output logic                    o_in_caption,
    output render_pkg::idx_t        o_index
);
    render_pkg::h_t h_min, cap_w, rel_h;
    render_pkg::v_t v_min, cap_h, rel_v;
    logic           active;

    always_comb begin
        active = 1'b1;
        h_min  = render_pkg::h_t'(render_pkg::START_CAP_H_MIN);
        v_min  = render_pkg::v_t'(render_pkg::START_CAP_V_MIN);
        cap_w  = render_pkg::h_t'(render_pkg::START_CAP_W);
        cap_h  = render_pkg::v_t'(render_pkg::START_CAP_H);
        case (i_game_state)
            render_pkg::ST_WIN: begin
                h_min = render_pkg::h_t'(render_pkg::WIN_CAP_H_MIN);
                v_min = render_pkg::v_t'(render_pkg::END_CAP_V_MIN);
                cap_w = render_pkg::h_t'(render_pkg::END_CAP_W);
                cap_h = render_pkg::v_t'(render_pkg::END_CAP_H);
            end
            render_pkg::ST_LOSE: begin
                h_min = render_pkg::h_t'(render_pkg::LOSE_CAP_H_MIN);
                v_min = render_pkg::v_t'(render_pkg::END_CAP_V_MIN);
                cap_w = render_pkg::h_t'(render_pkg::END_CAP_W);
                cap_h = render_pkg::v_t'(render_pkg::END_CAP_H);
            end
            render_pkg::ST_PLAY: begin
                active = 1'b0; // No caption during play.
            end
            default: begin
                active = 1'b1; // Idle keeps the start window.
            end
        endcase
    end

    assign rel_h = i_vga_h - h_min;
    assign rel_v = i_vga_v - v_min;

    assign o_in_caption = active && (rel_h < cap_w) && (rel_v < cap_h);
    assign o_index      = render_pkg::idx_t'(rel_v) * render_pkg::idx_t'(cap_w)
                          + render_pkg::idx_t'(rel_h);

endmodule

//--- hdl/object_priority.sv
`timescale 1ns/100ps

module object_priority (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_valid,
    input  render_pkg::game_state_e i_game_state,
    input  logic                    i_in_map,
    input  logic                    i_p1_shield,
    input  logic                    i_p2_shield,
    input  logic                    i_p1_hit,
    input  logic                    i_p1_opaque,
    input  render_pkg::idx_t        i_p1_index,
    input  logic                    i_p2_hit,
    input  logic                    i_p2_opaque,
    input  render_pkg::idx_t        i_p2_index,
    input  logic                    i_b1_hit,
    input  logic                    i_b1_opaque,
    input  render_pkg::idx_t        i_b1_index,
    input  logic                    i_b2_hit,
    input  logic                    i_b2_opaque,
    input  render_pkg::idx_t        i_b2_index,
    input  logic                    i_in_caption,
    input  render_pkg::idx_t        i_caption_index,
    input  render_pkg::idx_t        i_map_index,
    output logic                    o_valid,
    output render_pkg::object_id_e  o_object_id,
    output render_pkg::idx_t        o_index
);
    render_pkg::object_id_e obj;
    render_pkg::idx_t       idx;

    always_comb begin
        obj = render_pkg::OBJ_MAP; // Fallback for every transparent hit.
        idx = i_map_index;
        case (i_game_state)
            render_pkg::ST_PLAY: begin
                if (!i_in_map) begin
                    obj = render_pkg::OBJ_BLANK;
                    idx = '0;
                end else if (i_p1_hit) begin
                    if (i_p1_opaque || i_p1_shield) begin
                        obj = i_p1_opaque ? render_pkg::OBJ_PLAYER1
                                          : render_pkg::OBJ_PLAYER1_SHIELD;
                        idx = i_p1_index;
                    end
                end else if (i_p2_hit) begin
                    if (i_p2_opaque || i_p2_shield) begin
                        obj = i_p2_opaque ? render_pkg::OBJ_PLAYER2
                                          : render_pkg::OBJ_PLAYER2_SHIELD;
                        idx = i_p2_index;
                    end
                end else if (i_b1_hit) begin
                    if (i_b1_opaque) begin
                        obj = render_pkg::OBJ_BULLET1;
                        idx = i_b1_index;
                    end
                end else if (i_b2_hit && i_b2_opaque) begin
                    obj = render_pkg::OBJ_BULLET2;
                    idx = i_b2_index;
                end
            end
            render_pkg::ST_IDLE: begin
                obj = i_in_caption ? render_pkg::OBJ_START_CAPTION : render_pkg::OBJ_START_BG;
                idx = i_in_caption ? i_caption_index : i_map_index;
            end
            render_pkg::ST_WIN: begin
                obj = i_in_caption ? render_pkg::OBJ_WIN_CAPTION : render_pkg::OBJ_END_BG;
                idx = i_in_caption ? i_caption_index : i_map_index;
            end
            default: begin
                obj = i_in_caption ? render_pkg::OBJ_LOSE_CAPTION : render_pkg::OBJ_END_BG;
                idx = i_in_caption ? i_caption_index : i_map_index;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        o_object_id <= obj;
        o_index     <= idx;
    end

endmodule

//--- hdl/pixel_decoder.sv
`timescale 1ns/100ps

module pixel_decoder (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_psel,
    input  logic                   i_penable,
    input  logic                   i_pwrite,
    input  logic [7:0]             i_paddr,
    input  logic [31:0]            i_pwdata,
    output logic [31:0]            o_prdata,
    output logic                   o_pready,
    output logic                   o_pslverr,
    input  logic                   i_pixel_valid,
    input  render_pkg::h_t         i_vga_h,
    input  render_pkg::v_t         i_vga_v,
    output logic                   o_pixel_valid,
    output render_pkg::object_id_e o_object_id,
    output render_pkg::idx_t       o_pixel_index
);
    sprite_cfg_if #(.SIZE(render_pkg::PLAYER_SIZE)) p1_cfg ();
    sprite_cfg_if #(.SIZE(render_pkg::PLAYER_SIZE)) p2_cfg ();
    sprite_cfg_if #(.SIZE(render_pkg::BULLET_SIZE)) b1_cfg ();
    sprite_cfg_if #(.SIZE(render_pkg::BULLET_SIZE)) b2_cfg ();

    render_pkg::game_state_e game_state, s1_state;
    logic                    p1_shield, p2_shield;
    logic [1:0]              s1_shield;
    logic [3:0]              hit, opaque, s1_hit, s1_opaque; // P1, P2, B1, B2.
    render_pkg::idx_t        spr_idx [4];
    render_pkg::idx_t        s1_spr_idx [4];
    logic                    in_caption, s1_in_caption;
    render_pkg::idx_t        cap_idx, s1_cap_idx;
    render_pkg::idx_t        map_idx, s1_map_idx;
    logic                    in_map, s1_in_map;
    logic                    s1_valid;

    sprite_regs u_regs (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_psel       (i_psel),
        .i_penable    (i_penable),
        .i_pwrite     (i_pwrite),
        .i_paddr      (i_paddr),
        .i_pwdata     (i_pwdata),
        .o_prdata     (o_prdata),
        .o_pready     (o_pready),
        .o_pslverr    (o_pslverr),
        .o_game_state (game_state),
        .o_p1_shield  (p1_shield),
        .o_p2_shield  (p2_shield),
        .player1      (p1_cfg.cfg),
        .player2      (p2_cfg.cfg),
        .bullet1      (b1_cfg.cfg),
        .bullet2      (b2_cfg.cfg)
    );

    sprite_hit #(.SIZE(render_pkg::PLAYER_SIZE)) u_p1_hit (
        .cfg (p1_cfg.hit), .i_vga_h (i_vga_h), .i_vga_v (i_vga_v),
        .o_hit (hit[0]), .o_opaque (opaque[0]), .o_index (spr_idx[0])
    );
    sprite_hit #(.SIZE(render_pkg::PLAYER_SIZE)) u_p2_hit (
        .cfg (p2_cfg.hit), .i_vga_h (i_vga_h), .i_vga_v (i_vga_v),
        .o_hit (hit[1]), .o_opaque (opaque[1]), .o_index (spr_idx[1])
    );
    sprite_hit #(.SIZE(render_pkg::BULLET_SIZE)) u_b1_hit (
        .cfg (b1_cfg.hit), .i_vga_h (i_vga_h), .i_vga_v (i_vga_v),
        .o_hit (hit[2]), .o_opaque (opaque[2]), .o_index (spr_idx[2])
    );
    sprite_hit #(.SIZE(render_pkg::BULLET_SIZE)) u_b2_hit (
        .cfg (b2_cfg.hit), .i_vga_h (i_vga_h), .i_vga_v (i_vga_v),
        .o_hit (hit[3]), .o_opaque (opaque[3]), .o_index (spr_idx[3])
    );

    caption_select u_caption (
        .i_game_state (game_state),
        .i_vga_h      (i_vga_h),
        .i_vga_v      (i_vga_v),
        .o_in_caption (in_caption),
        .o_index      (cap_idx)
    );

    // Map rows are 1-based, so row zero is outside too.
    assign in_map  = (i_vga_v != '0) && (i_vga_v <= render_pkg::MAP_V);
    assign map_idx = render_pkg::idx_t'((i_vga_v - 1) * render_pkg::MAP_H + i_vga_h - 1);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= i_pixel_valid;
        end
    end

    // Stage one captures register values with the pixel.
    always_ff @(posedge i_clk) begin
        s1_state      <= game_state;
        s1_shield     <= {p2_shield, p1_shield};
        s1_hit        <= hit;
        s1_opaque     <= opaque;
        s1_spr_idx    <= spr_idx;
        s1_in_caption <= in_caption;
        s1_cap_idx    <= cap_idx;
        s1_map_idx    <= map_idx;
        s1_in_map     <= in_map;
    end

    object_priority u_priority (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_valid         (s1_valid),
        .i_game_state    (s1_state),
        .i_in_map        (s1_in_map),
        .i_p1_shield     (s1_shield[0]),
        .i_p2_shield     (s1_shield[1]),
        .i_p1_hit        (s1_hit[0]),
        .i_p1_opaque     (s1_opaque[0]),
        .i_p1_index      (s1_spr_idx[0]),
        .i_p2_hit        (s1_hit[1]),
        .i_p2_opaque     (s1_opaque[1]),
        .i_p2_index      (s1_spr_idx[1]),
        .i_b1_hit        (s1_hit[2]),
        .i_b1_opaque     (s1_opaque[2]),
        .i_b1_index      (s1_spr_idx[2]),
        .i_b2_hit        (s1_hit[3]),
        .i_b2_opaque     (s1_opaque[3]),
        .i_b2_index      (s1_spr_idx[3]),
        .i_in_caption    (s1_in_caption),
        .i_caption_index (s1_cap_idx),
        .i_map_index     (s1_map_idx),
        .o_valid         (o_pixel_valid),
        .o_object_id     (o_object_id),
        .o_index         (o_pixel_index)
    );

endmodule

//--- sim/tb_pixel_decoder.sv
`timescale 1ns/100ps

module tb_pixel_decoder;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int FIELDS       = 5; // Words per trace record.
    localparam int RECORDS      = 34;
    localparam int PIPE_DEPTH   = 2;
    localparam int unsigned SEED = 32'hf463adc2;

    localparam logic [3:0] OP_WRITE      = 4'h0;
    localparam logic [3:0] OP_READ       = 4'h1;
    localparam logic [3:0] OP_PIXEL      = 4'h2;
    localparam logic [3:0] OP_PIXEL_NEXT = 4'h3; // Issued on the cycle after the last pixel.
    localparam logic [3:0] OP_END        = 4'hf;

    logic                   clk;
    logic                   rst_n;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [7:0]             paddr;
    logic [31:0]            pwdata;
    logic [31:0]            prdata;
    logic                   pready;
    logic                   pslverr;
    logic                   pixel_valid;
    render_pkg::h_t         vga_h;
    render_pkg::v_t         vga_v;
    logic                   out_valid;
    render_pkg::object_id_e out_id;
    render_pkg::idx_t       out_index;

    logic [31:0] trace_mem [0:RECORDS*FIELDS-1];
    int          num_records = 0;
    int          errors = 0;
    int          passed = 0;
    int          failed = 0;

    // Expected pixel results, delayed to line up with the DUT output.
    logic             req_valid;
    logic [3:0]       req_id;
    render_pkg::idx_t req_index;
    int               req_test;
    logic             pipe_valid [PIPE_DEPTH];
    logic [3:0]       pipe_id [PIPE_DEPTH];
    render_pkg::idx_t pipe_index [PIPE_DEPTH];
    int               pipe_test [PIPE_DEPTH];

    pixel_decoder dut (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_psel        (psel),
        .i_penable     (penable),
        .i_pwrite      (pwrite),
        .i_paddr       (paddr),
        .i_pwdata      (pwdata),
        .o_prdata      (prdata),
        .o_pready      (pready),
        .o_pslverr     (pslverr),
        .i_pixel_valid (pixel_valid),
        .i_vga_h       (vga_h),
        .i_vga_v       (vga_v),
        .o_pixel_valid (out_valid),
        .o_object_id   (out_id),
        .o_pixel_index (out_index)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        pipe_valid[0] <= req_valid;
        pipe_id[0]    <= req_id;
        pipe_index[0] <= req_index;
        pipe_test[0]  <= req_test;
        pipe_valid[1] <= pipe_valid[0];
        pipe_id[1]    <= pipe_id[0];
        pipe_index[1] <= pipe_index[0];
        pipe_test[1]  <= pipe_test[0];
    end

    task automatic report_result(input int test, input string desc, input logic ok);
        if (ok) begin
            $display("test %0d %s: pass", test, desc);
            passed++;
        end else begin
            $display("test %0d %s: FAIL", test, desc);
            failed++;
            errors++;
        end
    endtask

    task automatic check_pixel(input int test, input logic [3:0] exp_id,
                               input render_pkg::idx_t exp_index);
        logic ok;
        ok = 1'b1;
        assert (out_id == exp_id) else begin
            $display("mismatch test %0d object id: expected 0x%0h, actual 0x%0h",
                     test, exp_id, out_id);
            ok = 1'b0;
        end
        assert (out_index == exp_index) else begin
            $display("mismatch test %0d pixel index: expected 0x%0h, actual 0x%0h",
                     test, exp_index, out_index);
            ok = 1'b0;
        end
        report_result(test, "pixel", ok);
    endtask

    // Outputs are sampled half a cycle after they change.
    always @(negedge clk) begin
        if (rst_n) begin
            assert (out_valid == pipe_valid[PIPE_DEPTH-1]) else begin
                $display("mismatch pixel valid: expected %0b, actual %0b",
                         pipe_valid[PIPE_DEPTH-1], out_valid);
                errors++;
            end
            if (pipe_valid[PIPE_DEPTH-1]) begin
                check_pixel(pipe_test[PIPE_DEPTH-1], pipe_id[PIPE_DEPTH-1],
                            pipe_index[PIPE_DEPTH-1]);
            end
        end
    end

    task automatic apb_access(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        psel    = 1'b1; // Setup phase.
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        assert (pready) else begin
            $display("Error: o_pready was low during the access phase at 0x%02h", addr);
            errors++;
        end
        rdata   = prdata;
        err     = pslverr;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic run_apb_test(input int test, input logic [3:0] op,
                                input logic [7:0] addr, input logic [31:0] wdata,
                                input logic [31:0] exp_data, input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        logic        ok;
        ok = 1'b1;
        apb_access(op == OP_WRITE, addr, wdata, rdata, err);
        if (op == OP_READ) begin
            assert (rdata == exp_data) else begin
                $display("mismatch test %0d read data at 0x%02h: expected 0x%08h, actual 0x%08h",
                         test, addr, exp_data, rdata);
                ok = 1'b0;
            end
        end
        assert (err == exp_err) else begin
            $display("mismatch test %0d pslverr at 0x%02h: expected %0b, actual %0b",
                     test, addr, exp_err, err);
            ok = 1'b0;
        end
        report_result(test, $sformatf("%s 0x%02h", (op == OP_READ) ? "read" : "write", addr), ok);
    endtask

    task automatic send_pixel(input int test, input logic [31:0] h, input logic [31:0] v,
                              input logic [31:0] exp_id, input logic [31:0] exp_index);
        pixel_valid = 1'b1;
        vga_h       = h[7:0];
        vga_v       = v[6:0];
        req_valid   = 1'b1;
        req_id      = exp_id[3:0];
        req_index   = exp_index[14:0];
        req_test    = test;
        @(negedge clk);
        pixel_valid = 1'b0;
        req_valid   = 1'b0;
    endtask

    initial begin
        int          gap;
        int          base;
        int          count;
        logic [3:0]  op;
        rst_n       = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        pixel_valid = 1'b0;
        vga_h       = '0;
        vga_v       = '0;
        req_valid   = 1'b0;
        req_id      = '0;
        req_index   = '0;
        req_test    = 0;
        void'($urandom(SEED));
        $readmemh("sim/pixel_trace.txt", trace_mem);
        count = 0;
        while (count < RECORDS && trace_mem[count*FIELDS][3:0] != OP_END) begin
            count++;
        end
        num_records = count;
        assert (num_records > 0) else begin
            $display("Error: the trace file holds no records");
            errors++;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        for (int i = 0; i < num_records; i++) begin
            base = i * FIELDS;
            op   = trace_mem[base][3:0];
            if (op != OP_PIXEL_NEXT) begin
                gap = int'($urandom % 3); // Idle cycles before this record.
                repeat (gap) @(negedge clk);
            end
            case (op)
                OP_WRITE, OP_READ: begin
                    run_apb_test(i + 1, op, trace_mem[base+1][7:0], trace_mem[base+2],
                                 trace_mem[base+3], trace_mem[base+4][0]);
                end
                OP_PIXEL, OP_PIXEL_NEXT: begin
                    send_pixel(i + 1, trace_mem[base+1], trace_mem[base+2],
                               trace_mem[base+3], trace_mem[base+4]);
                end
                default: begin
                    $display("Error: trace record %0d has an unknown opcode %0h", i + 1, op);
                    errors++;
                end
            endcase
        end
        repeat (PIPE_DEPTH + 1) @(negedge clk); // Let the last pixels drain.
        $display("Tests: %0d, passed: %0d, failed: %0d, other errors: %0d",
                 passed + failed, passed, failed, errors - failed);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Ten cycles per trace record is well above the longest record.
    initial begin
        wait (num_records > 0);
        repeat (num_records * 10 + RESET_CYCLES) @(posedge clk);
        $display("Error: timeout, the trace did not finish within %0d cycles",
                 num_records * 10 + RESET_CYCLES);
        $display("Verification failed");
        $finish;
    end

endmodule

//--- sim/pixel_trace.txt
// op a b c d  (hex) op 0 write: a addr, b data, d exp pslverr; op 1 read: a addr, c exp data,
// d exp pslverr; op 2 pixel: a h, b v, c exp object id, d exp index; op 3 same, no gap; op f end.
2 29 33 7 0
3 78 46 7 63f
2 0a 05 8 289
1 14 0 0 1
0 00 2 0 0
1 00 0 2 0
2 39 2e 9 0
3 38 2e b 1c57
0 00 3 0 0
2 32 2f a 31
0 40 81 0 0
0 04 80000000 0 0
1 04 0 80000000 0
0 68 ff 0 0
0 08 80000004 0 0
0 00 5 0 0
2 4d 39 1 0
3 4e 39 2 1
3 51 3b 2 14
2 55 3b 3 14
2 56 3c 0 2535
0 0c ec 0 0
2 3b 3b 0 247a
0 80 1 0 0
0 0c 800000ec 0 0
2 3b 3b 5 0
3 3c 3b 0 247b
0 84 ffff 0 0
0 10 800000fe 0 0
2 4d 3b 2 10
1 84 0 ffff 0
2 0a 79 c 0
3 0a 78 0 4a69
f 0 0 0 0

//--- verilog.f
hdl/render_pkg.sv
hdl/sprite_cfg_if.sv
hdl/sprite_regs.sv
hdl/sprite_hit.sv
hdl/caption_select.sv
hdl/object_priority.sv
hdl/pixel_decoder.sv
sim/tb_pixel_decoder.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the pixel decoder testbench with Verilator.
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_pixel_decoder -f verilog.f -o sim_pixel_decoder

./obj_dir/sim_pixel_decoder | tee sim.log

if grep -q "Verification failed" sim.log; then
    exit 1
fi
exit 0
